//--- minimux_pkg.sv
//----------------------------------------
// Shared types and widths of the 32 channel
// mini-multiplexer board controller
// Imported by every RTL module
//----------------------------------------

package minimux_pkg;

    //----------------------------------------
    // Converter sync
    //----------------------------------------

    // Output behaviour of a sync pin
    typedef enum logic [1:0] {
        sync_clocked = 2'd0,  // Divided clk100
        sync_high_z  = 2'd1,  // Pin released
        sync_fixed_0 = 2'd2,
        sync_fixed_1 = 2'd3
    } sync_mode_t;

    //----------------------------------------
    // Channel mapping
    //----------------------------------------

    localparam int N_SENDERS = 32;

    typedef logic [5:0] muxch_t;   // [5] idle, [4:0] sender 0..31
    typedef logic [4:0] mux_sel_t; // [4] bank (0 = mux 1), [3:0] address

    //----------------------------------------
    // Encoder and status
    //----------------------------------------

    localparam int DEBOUNCE_W = 16;
    localparam int COUNT_W    = 16; // Signed position
    localparam int ERR_W      = 8;  // Saturating
    localparam int N_OVLD     = 4;
    localparam int N_STATUS   = 3;

    // Bit positions in the status word
    typedef enum logic [1:0] {
        st_ovld = 2'd0,
        st_sflt = 2'd1,
        st_inc  = 2'd2
    } status_bit_t;

endpackage

//--- power_control.sv
//----------------------------------------
// Power-up time base, converter enable,
// ready flag and converter sync outputs
//----------------------------------------

`timescale 1ns/1ps

module power_control import minimux_pkg::*; #(
    parameter int CLKS_PER_MS      = 100000,
    parameter int MS_PER_S         = 1000,
    parameter int SYNC_HALF_PERIOD = 25
) (
    input  logic       i_clk100,
    input  logic       pre_reset,
    output logic       o_conv_en,      // 6 V converters on
    output logic       o_init_ready,   // System ready
    output logic       o_seconds_lsb,  // Blue LED blink
    input  sync_mode_t i_v3_sync_mode,
    input  sync_mode_t i_v6_sync_mode,
    output logic       o_v3_sync,
    output logic       o_v6_sync
);

    localparam int CLK_W  = $clog2(CLKS_PER_MS + 1);
    localparam int MS_W   = $clog2(MS_PER_S + 1);
    localparam int SYNC_W = $clog2(SYNC_HALF_PERIOD + 1);

    logic [CLK_W-1:0]  cnt_clk;   // Cycles within a ms
    logic [MS_W-1:0]   cnt_ms;    // ms within a second
    logic [2:0]        cnt_s;     // Seconds, wraps
    logic              ms_tick;
    logic              s_tick;
    logic [SYNC_W-1:0] cnt_sync;
    logic              sync_clk;

    // Pin level for one sync mode
    function automatic logic sync_pin(input sync_mode_t mode, input logic clk_div);
        logic pin;
        unique case (mode)
            sync_clocked: pin = clk_div;
            sync_high_z:  pin = 1'bz;
            sync_fixed_0: pin = 1'b0;
            sync_fixed_1: pin = 1'b1;
        endcase
        return pin;
    endfunction

    //----------------------------------------
    // Time base
    //----------------------------------------

    assign ms_tick = (cnt_clk == CLK_W'(CLKS_PER_MS - 1));
    assign s_tick  = ms_tick && (cnt_ms == MS_W'(MS_PER_S - 1));

    always_ff @(posedge i_clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            cnt_clk <= '0;
            cnt_ms  <= '0;
            cnt_s   <= '0;
        end else begin
            cnt_clk <= ms_tick ? '0 : cnt_clk + 1'b1;
            if (s_tick) begin
                cnt_ms <= '0;
                cnt_s  <= cnt_s + 1'b1;
            end else if (ms_tick) begin
                cnt_ms <= cnt_ms + 1'b1;
            end
        end
    end

    // Set on the edge that enters second 1 / second 2, sticky afterwards
    always_ff @(posedge i_clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            o_conv_en    <= 1'b0;
            o_init_ready <= 1'b0;
        end else begin
            if (s_tick && cnt_s == 3'd0) o_conv_en <= 1'b1;
            if (s_tick && cnt_s == 3'd1) o_init_ready <= 1'b1;
        end
    end

    assign o_seconds_lsb = cnt_s[0];

    //----------------------------------------
    // Sync clock divider
    //----------------------------------------

    always_ff @(posedge i_clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            cnt_sync <= '0;
            sync_clk <= 1'b0;
        end else if (cnt_sync == SYNC_W'(SYNC_HALF_PERIOD - 1)) begin
            cnt_sync <= '0;
            sync_clk <= ~sync_clk;  // Half period done
        end else begin
            cnt_sync <= cnt_sync + 1'b1;
        end
    end

    // Mode select is combinational
    always_comb begin
        o_v3_sync = sync_pin(i_v3_sync_mode, sync_clk);
        o_v6_sync = sync_pin(i_v6_sync_mode, sync_clk);
    end

    // Ready must come after the converters are up
    a_ready_after_conv: assert property (@(posedge i_clk100) disable iff (pre_reset)
        $rose(o_init_ready) |-> $past(o_conv_en));

endmodule

//--- channel_map.sv
//----------------------------------------
// Channel number to sender enable and
// P/N receive multiplexer selection
//----------------------------------------

`timescale 1ns/1ps

module channel_map import minimux_pkg::*; (
    input  logic                 i_clk100,
    input  logic                 pre_reset,
    input  logic                 i_init_ready,
    input  muxch_t               i_muxch,
    output logic [N_SENDERS-1:0] o_en_snd,     // One-hot, active high
    output mux_sel_t             o_mux_p,
    output mux_sel_t             o_mux_n,
    output logic                 o_mux_valid   // Selection active
);

    logic       sel_active;
    logic [4:0] snd;

    assign snd        = i_muxch[4:0];
    assign sel_active = i_init_ready && !i_muxch[5];  // Bit 5 = idle

    always_ff @(posedge i_clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            o_en_snd    <= '0;
            o_mux_p     <= '0;
            o_mux_n     <= '0;
            o_mux_valid <= 1'b0;
        end else if (!sel_active) begin
            // Idle: no sender, both muxes off
            o_en_snd    <= '0;
            o_mux_p     <= '0;
            o_mux_n     <= '0;
            o_mux_valid <= 1'b0;
        end else begin
            o_en_snd    <= N_SENDERS'(1) << snd;
            o_mux_p     <= snd;
            o_mux_n     <= snd ^ 5'd16;  // N always on the other bank
            o_mux_valid <= 1'b1;
        end
    end

    // Never two senders at once
    a_one_sender: assert property (@(posedge i_clk100) disable iff (pre_reset)
        $onehot0(o_en_snd));

endmodule

//--- input_debouncer.sv
//----------------------------------------
// Level filter, passes the input once it
// has been stable for i_width+1 cycles
//----------------------------------------

`timescale 1ns/1ps

module input_debouncer import minimux_pkg::*; (
    input  logic                  i_clk100,
    input  logic                  pre_reset,
    input  logic [DEBOUNCE_W-1:0] i_width,
    input  logic                  i_signal,
    output logic                  o_signal
);

    logic                  sample;  // Last seen level
    logic [DEBOUNCE_W-1:0] cnt;     // Stable cycles

    always_ff @(posedge i_clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            sample   <= 1'b0;
            cnt      <= '0;
            o_signal <= 1'b0;
        end else begin
            sample <= i_signal;
            if (i_signal != sample) begin
                cnt <= '0;  // Restart on any change
            end else if (cnt < i_width) begin
                cnt <= cnt + 1'b1;
            end else begin
                o_signal <= sample;
            end
        end
    end

endmodule

//--- quad_decoder.sv
//----------------------------------------
// 4x quadrature decoder with inc/dec/zero
// pulses, position and error counters
//----------------------------------------

`timescale 1ns/1ps

module quad_decoder import minimux_pkg::*; (
    input  logic                      i_clk100,
    input  logic                      pre_reset,
    input  logic                      i_a,
    input  logic                      i_b,
    input  logic                      i_n,
    output logic                      o_inc_pulse,
    output logic                      o_dec_pulse,
    output logic                      o_zero_pulse,
    output logic signed [COUNT_W-1:0] o_counter_ab,
    output logic signed [COUNT_W-1:0] o_counter_at_zero,  // Position at last zero
    output logic [ERR_W-1:0]          o_counter_err
);

    logic [1:0] ab;
    logic [1:0] ab_q;   // Previous A/B
    logic       n_q;
    logic       step_up;
    logic       step_dn;
    logic       step_err;

    assign ab = {i_a, i_b};

    // Gray steps, A leads B counts up
    always_comb begin
        step_up = 1'b0;
        step_dn = 1'b0;
        case ({ab_q, ab})
            4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_up = 1'b1;
            4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step_dn = 1'b1;
            default: ;  // No change or error
        endcase
    end

    assign step_err = (ab_q[1] != ab[1]) && (ab_q[0] != ab[0]);  // Both moved

    always_ff @(posedge i_clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            ab_q              <= 2'b00;
            n_q               <= 1'b0;
            o_inc_pulse       <= 1'b0;
            o_dec_pulse       <= 1'b0;
            o_zero_pulse      <= 1'b0;
            o_counter_ab      <= '0;
            o_counter_at_zero <= '0;
            o_counter_err     <= '0;
        end else begin
            ab_q         <= ab;
            n_q          <= i_n;
            o_inc_pulse  <= step_up;
            o_dec_pulse  <= step_dn;
            o_zero_pulse <= i_n && !n_q;

            if (step_up)
                o_counter_ab <= o_counter_ab + COUNT_W'(1);
            else if (step_dn)
                o_counter_ab <= o_counter_ab - COUNT_W'(1);

            if (step_err && o_counter_err != '1)
                o_counter_err <= o_counter_err + 1'b1;  // Saturate

            if (i_n && !n_q)
                o_counter_at_zero <= o_counter_ab;  // Latch on zero edge
        end
    end

    a_inc_dec_excl: assert property (@(posedge i_clk100) disable iff (pre_reset)
        !(o_inc_pulse && o_dec_pulse));

endmodule

//--- status_trigger.sv
//----------------------------------------
// Overload sync, trigger gating and the
// sticky status bits with acknowledge
//----------------------------------------

`timescale 1ns/1ps

module status_trigger import minimux_pkg::*; (
    input  logic                i_clk100,
    input  logic                pre_reset,
    input  logic                i_init_ready,
    input  logic                i_switching_ready,
    input  logic [N_OVLD-1:0]   i_ovld,        // Bit 0 is OVLD1
    input  logic                i_inc_pulse,
    input  logic                i_status_ack,  // One cycle
    output logic [N_STATUS-1:0] o_status,
    output logic                o_ovld_any     // Red LED
);

    logic [N_OVLD-1:0]   ovld_s1;
    logic [N_OVLD-1:0]   ovld_s2;
    logic                ovld;
    logic                sflt;
    logic                gate;
    logic [N_STATUS-1:0] trig;
    logic [N_STATUS-1:0] trig_q;

    assign ovld = |ovld_s2;
    assign sflt = ovld_s2[1] & ovld_s2[2] & ~ovld_s2[0] & ~ovld_s2[3];  // 2,3 on; 1,4 off
    assign gate = i_init_ready & i_switching_ready;

    always_comb begin
        trig          = '0;
        trig[st_ovld] = gate & ovld & ~sflt;
        trig[st_sflt] = gate & sflt;
        trig[st_inc]  = i_inc_pulse;
    end

    // Sync, trigger register, then sticky bits
    always_ff @(posedge i_clk100 or posedge pre_reset) begin
        if (pre_reset) begin
            ovld_s1  <= '0;
            ovld_s2  <= '0;
            trig_q   <= '0;
            o_status <= '0;
        end else begin
            ovld_s1 <= i_ovld;
            ovld_s2 <= ovld_s1;
            trig_q  <= trig;
            if (i_status_ack)
                o_status <= trig_q;  // Fresh cause beats the ack
            else
                o_status <= o_status | trig_q;
        end
    end

    assign o_ovld_any = ovld;

endmodule

//--- minimux_top.sv
//----------------------------------------
// Board controller top level, 32 channel
// array mini-multiplexer
// Instances, open-drain pins and mux enables
//----------------------------------------

`timescale 1ns/1ps

module minimux_top import minimux_pkg::*; #(
    parameter int CLKS_PER_MS      = 100000,
    parameter int MS_PER_S         = 1000,
    parameter int SYNC_HALF_PERIOD = 25     // 2 MHz sync
) (
    input  logic                      i_clk100,
    input  logic                      pre_reset,
    input  muxch_t                    i_muxch,
    input  sync_mode_t                i_v3_sync_mode,
    input  sync_mode_t                i_v6_sync_mode,
    input  logic [DEBOUNCE_W-1:0]     i_debounce_width,
    input  logic                      i_enc_a,
    input  logic                      i_enc_b,
    input  logic                      i_enc_0,
    input  logic [N_OVLD-1:0]         i_ovld,
    input  logic                      i_switching_ready,
    input  logic                      i_status_ack,
    output wire  [N_SENDERS-1:0]      o_en_snd_n,    // Open drain
    output logic [3:0]                o_mux_p_addr,
    output logic [3:0]                o_mux_n_addr,
    output logic                      o_mux1p_en,
    output logic                      o_mux2p_en,
    output logic                      o_mux1n_en,
    output logic                      o_mux2n_en,
    output logic                      o_v3_sync,
    output logic                      o_v6_sync,
    output logic                      o_v6p_en,
    output logic                      o_v6n_en,
    output wire                       o_led_red,     // Open drain
    output wire                       o_led_grn,
    output wire                       o_led_blu,
    output logic                      o_trg_n,
    output logic [N_STATUS-1:0]       o_status,
    output logic signed [COUNT_W-1:0] o_counter_ab,
    output logic signed [COUNT_W-1:0] o_counter_at_zero,
    output logic [ERR_W-1:0]          o_counter_err
);

    logic                 conv_en;
    logic                 init_ready;
    logic                 seconds_lsb;
    logic [N_SENDERS-1:0] en_snd;
    mux_sel_t             mux_p;
    mux_sel_t             mux_n;
    logic                 mux_valid;
    logic [2:0]           enc_raw;
    logic [2:0]           enc_deb;   // {zero, B, A} debounced
    logic                 inc_pulse;
    logic                 zero_pulse;
    logic                 ovld_any;

    //----------------------------------------
    // Power sequencing and sync
    //----------------------------------------

    power_control #(
        .CLKS_PER_MS      (CLKS_PER_MS),
        .MS_PER_S         (MS_PER_S),
        .SYNC_HALF_PERIOD (SYNC_HALF_PERIOD)
    ) u_power (
        .i_clk100       (i_clk100),
        .pre_reset      (pre_reset),
        .o_conv_en      (conv_en),
        .o_init_ready   (init_ready),
        .o_seconds_lsb  (seconds_lsb),
        .i_v3_sync_mode (i_v3_sync_mode),
        .i_v6_sync_mode (i_v6_sync_mode),
        .o_v3_sync      (o_v3_sync),
        .o_v6_sync      (o_v6_sync)
    );

    assign o_v6p_en = conv_en;  // Both rails together
    assign o_v6n_en = conv_en;

    //----------------------------------------
    // Sender and receive mux mapping
    //----------------------------------------

    channel_map u_map (
        .i_clk100     (i_clk100),
        .pre_reset    (pre_reset),
        .i_init_ready (init_ready),
        .i_muxch      (i_muxch),
        .o_en_snd     (en_snd),
        .o_mux_p      (mux_p),
        .o_mux_n      (mux_n),
        .o_mux_valid  (mux_valid)
    );

    for (genvar s = 0; s < N_SENDERS; s++) begin : g_snd
        assign o_en_snd_n[s] = en_snd[s] ? 1'b0 : 1'bz;  // Sender amp enable
    end

    assign o_mux_p_addr = mux_p[3:0];
    assign o_mux_n_addr = mux_n[3:0];
    assign o_mux1p_en   = mux_valid & ~mux_p[4];  // Bank 0 -> mux 1
    assign o_mux2p_en   = mux_valid &  mux_p[4];
    assign o_mux1n_en   = mux_valid & ~mux_n[4];
    assign o_mux2n_en   = mux_valid &  mux_n[4];

    //----------------------------------------
    // Quadrature encoder
    //----------------------------------------

    assign enc_raw = {i_enc_0, i_enc_b, i_enc_a};

    for (genvar i = 0; i < 3; i++) begin : g_deb
        input_debouncer u_deb (
            .i_clk100  (i_clk100),
            .pre_reset (pre_reset),
            .i_width   (i_debounce_width),
            .i_signal  (enc_raw[i]),
            .o_signal  (enc_deb[i])
        );
    end

    quad_decoder u_quad (
        .i_clk100          (i_clk100),
        .pre_reset         (pre_reset),
        .i_a               (enc_deb[0]),
        .i_b               (enc_deb[1]),
        .i_n               (enc_deb[2]),
        .o_inc_pulse       (inc_pulse),
        .o_dec_pulse       (),
        .o_zero_pulse      (zero_pulse),
        .o_counter_ab      (o_counter_ab),
        .o_counter_at_zero (o_counter_at_zero),
        .o_counter_err     (o_counter_err)
    );

    assign o_trg_n = ~zero_pulse;  // Trigger out, active low

    //----------------------------------------
    // Status and LEDs
    //----------------------------------------

    status_trigger u_status (
        .i_clk100          (i_clk100),
        .pre_reset         (pre_reset),
        .i_init_ready      (init_ready),
        .i_switching_ready (i_switching_ready),
        .i_ovld            (i_ovld),
        .i_inc_pulse       (inc_pulse),
        .i_status_ack      (i_status_ack),
        .o_status          (o_status),
        .o_ovld_any        (ovld_any)
    );

    // LED on = pulled low
    assign o_led_red = ovld_any    ? 1'b0 : 1'bz;
    assign o_led_grn = init_ready  ? 1'b0 : 1'bz;
    assign o_led_blu = seconds_lsb ? 1'b0 : 1'bz;

endmodule

//--- tb_minimux.sv
//----------------------------------------
// Directed testbench for the mini-mux board
// controller with a short time base of 100 cycles per second
//----------------------------------------

`timescale 1ns/1ps

module tb_minimux import minimux_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;  // Tests need about 450

    logic                      clk100;
    logic                      pre_reset;
    muxch_t                    muxch;
    sync_mode_t                v3_mode;
    sync_mode_t                v6_mode;
    logic [DEBOUNCE_W-1:0]     deb_width;
    logic                      enc_a;
    logic                      enc_b;
    logic                      enc_0;
    logic [N_OVLD-1:0]         ovld;
    logic                      sw_ready;
    logic                      status_ack;
    wire  [N_SENDERS-1:0]      en_snd_n;
    logic [3:0]                mux_p_addr;
    logic [3:0]                mux_n_addr;
    logic                      mux1p_en;
    logic                      mux2p_en;
    logic                      mux1n_en;
    logic                      mux2n_en;
    logic                      v3_sync;
    logic                      v6_sync;
    logic                      v6p_en;
    logic                      v6n_en;
    wire                       led_red;
    wire                       led_grn;
    wire                       led_blu;
    logic                      trg_n;
    logic [N_STATUS-1:0]       status;
    logic signed [COUNT_W-1:0] counter_ab;
    logic signed [COUNT_W-1:0] counter_at_zero;
    logic [ERR_W-1:0]          counter_err;

    int     errors;
    int     checks;
    int     cycles;
    int     enc_idx;  // Position in the Gray sequence
    integer seed = 44;

    minimux_top #(
        .CLKS_PER_MS      (10),
        .MS_PER_S         (10),
        .SYNC_HALF_PERIOD (3)
    ) i_dut (
        .i_clk100          (clk100),
        .pre_reset         (pre_reset),
        .i_muxch           (muxch),
        .i_v3_sync_mode    (v3_mode),
        .i_v6_sync_mode    (v6_mode),
        .i_debounce_width  (deb_width),
        .i_enc_a           (enc_a),
        .i_enc_b           (enc_b),
        .i_enc_0           (enc_0),
        .i_ovld            (ovld),
        .i_switching_ready (sw_ready),
        .i_status_ack      (status_ack),
        .o_en_snd_n        (en_snd_n),
        .o_mux_p_addr      (mux_p_addr),
        .o_mux_n_addr      (mux_n_addr),
        .o_mux1p_en        (mux1p_en),
        .o_mux2p_en        (mux2p_en),
        .o_mux1n_en        (mux1n_en),
        .o_mux2n_en        (mux2n_en),
        .o_v3_sync         (v3_sync),
        .o_v6_sync         (v6_sync),
        .o_v6p_en          (v6p_en),
        .o_v6n_en          (v6n_en),
        .o_led_red         (led_red),
        .o_led_grn         (led_grn),
        .o_led_blu         (led_blu),
        .o_trg_n           (trg_n),
        .o_status          (status),
        .o_counter_ab      (counter_ab),
        .o_counter_at_zero (counter_at_zero),
        .o_counter_err     (counter_err)
    );

    initial begin
        clk100 = 1'b0;
        forever #4 clk100 = ~clk100;  // 8 ns period
    end

    // Run limit
    always @(posedge clk100) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    //----------------------------------------
    // Helpers
    //----------------------------------------

    // Returns 1 ns after the n-th rising edge where inputs change
    task wait_cycles(input int n);
        repeat (n) @(posedge clk100);
        #1;
    endtask

    // Four-state compare of a value against its expected value
    task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Forward Gray sequence with A leading B
    function automatic logic [1:0] gray_ab(input int idx);
        case (idx & 3)
            0:       return 2'b00;
            1:       return 2'b10;
            2:       return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    // Quadrature step in direction dir (+1 or -1) held for 6 cycles
    task encoder_step(input int dir);
        enc_idx = enc_idx + dir;
        {enc_a, enc_b} = gray_ab(enc_idx);
        wait_cycles(6);
    endtask

    task ack_status;
        status_ack = 1'b1;
        wait_cycles(1);
        status_ack = 1'b0;
        wait_cycles(2);
    endtask

    //----------------------------------------
    // Tests
    //----------------------------------------

    task test_power_up;
        check_value("o_v6p_en", v6p_en, 1'b0);
        check_value("o_led_grn", led_grn, 1'bz);
        check_value("o_en_snd_n", en_snd_n, {N_SENDERS{1'bz}});
        wait_cycles(99);
        check_value("o_v6p_en", v6p_en, 1'b0);  // One cycle before second 1
        check_value("o_led_blu", led_blu, 1'bz);
        wait_cycles(1);
        check_value("o_v6p_en", v6p_en, 1'b1);
        check_value("o_v6n_en", v6n_en, 1'b1);
        check_value("o_led_blu", led_blu, 1'b0);
        wait_cycles(99);
        check_value("o_led_grn", led_grn, 1'bz);
        check_value("o_led_blu", led_blu, 1'b0);
        wait_cycles(1);
        check_value("o_led_grn", led_grn, 1'b0);  // Ready at second 2
        check_value("o_led_blu", led_blu, 1'bz);
    endtask

    task test_sync_modes;
        int   n;
        logic level;
        v3_mode = sync_high_z;
        v6_mode = sync_high_z;
        wait_cycles(1);
        check_value("o_v3_sync", v3_sync, 1'bz);
        check_value("o_v6_sync", v6_sync, 1'bz);
        v3_mode = sync_fixed_0;
        v6_mode = sync_fixed_0;
        wait_cycles(1);
        check_value("o_v3_sync", v3_sync, 1'b0);
        check_value("o_v6_sync", v6_sync, 1'b0);
        v3_mode = sync_fixed_1;
        v6_mode = sync_fixed_1;
        wait_cycles(1);
        check_value("o_v3_sync", v3_sync, 1'b1);
        check_value("o_v6_sync", v6_sync, 1'b1);
        v3_mode = sync_clocked;
        wait_cycles(1);
        // Find a toggle and then expect one every 3 cycles
        n     = 0;
        level = v3_sync;
        while (v3_sync === level && n < 4) begin
            wait_cycles(1);
            n++;
        end
        if (n == 4) begin
            errors++;
            $display("o_v3_sync did not toggle in clocked mode");
        end
        level = v3_sync;
        for (int k = 1; k <= 6; k++) begin
            wait_cycles(1);
            check_value("o_v3_sync", v3_sync, level ^ ((k / 3) % 2));
        end
    endtask

    task test_channel_map;
        logic [4:0]           s;
        logic [N_SENDERS-1:0] exp_snd;
        for (int i = 0; i < 20; i++) begin
            s     = $random(seed);
            muxch = {1'b0, s};
            wait_cycles(1);
            exp_snd    = {N_SENDERS{1'bz}};
            exp_snd[s] = 1'b0;  // Only the selected sender pulled low
            check_value("o_en_snd_n", en_snd_n, exp_snd);
            check_value("o_mux_p_addr", mux_p_addr, s[3:0]);
            check_value("o_mux_n_addr", mux_n_addr, s[3:0]);
            check_value("o_mux1p_en", mux1p_en, !s[4]);
            check_value("o_mux2p_en", mux2p_en, s[4]);
            check_value("o_mux1n_en", mux1n_en, s[4]);   // N on the other bank
            check_value("o_mux2n_en", mux2n_en, !s[4]);
        end
        muxch = 6'h20 | 6'($random(seed));  // Idle flag set
        wait_cycles(1);
        check_value("o_en_snd_n", en_snd_n, {N_SENDERS{1'bz}});
        check_value("mux enables", {mux1p_en, mux2p_en, mux1n_en, mux2n_en}, 4'b0000);
    endtask

    task test_encoder;
        int low_cycles;
        deb_width = 16'd2;
        wait_cycles(1);
        for (int i = 0; i < 10; i++)
            encoder_step(1);
        for (int i = 0; i < 4; i++)
            encoder_step(-1);
        check_value("o_counter_ab", counter_ab, 16'sd6);
        // Zero pulse
        enc_0      = 1'b1;
        low_cycles = 0;
        for (int i = 0; i < 12; i++) begin
            wait_cycles(1);
            if (trg_n === 1'b0)
                low_cycles++;
        end
        check_value("o_trg_n low cycles", low_cycles, 1);
        check_value("o_counter_at_zero", counter_at_zero, 16'sd6);
        enc_0 = 1'b0;
        wait_cycles(6);
        // Both lines at once
        {enc_a, enc_b} = ~gray_ab(enc_idx);
        enc_idx        = enc_idx + 2;
        wait_cycles(6);
        check_value("o_counter_err", counter_err, 8'd1);
        check_value("o_counter_ab", counter_ab, 16'sd6);
    endtask

    task test_status;
        ack_status();  // Clear inc bits left by the encoder test
        check_value("o_status", status, 3'b000);
        sw_ready = 1'b0;
        ovld     = 4'b0001;
        wait_cycles(6);
        check_value("o_status", status, 3'b000);
        check_value("o_led_red", led_red, 1'b0);
        sw_ready = 1'b1;
        wait_cycles(6);
        check_value("o_status", status, 3'b001);
        check_value("o_led_red", led_red, 1'b0);
        ovld = 4'b0000;
        wait_cycles(4);
        ack_status();
        check_value("o_status", status, 3'b000);
        check_value("o_led_red", led_red, 1'bz);
        // Sensor fault pattern on inputs 2 and 3
        ovld = 4'b0110;
        wait_cycles(6);
        check_value("o_status", status, 3'b010);
        ovld = 4'b0000;
        wait_cycles(4);
        ack_status();
        check_value("o_status", status, 3'b000);
        encoder_step(1);
        wait_cycles(3);
        check_value("o_status", status, 3'b100);
        ack_status();
        check_value("o_status", status, 3'b000);
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------

    initial begin
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        enc_idx    = 0;
        pre_reset  = 1'b1;
        muxch      = 6'h20;
        v3_mode    = sync_high_z;
        v6_mode    = sync_high_z;
        deb_width  = '0;
        enc_a      = 1'b0;
        enc_b      = 1'b0;
        enc_0      = 1'b0;
        ovld       = '0;
        sw_ready   = 1'b0;
        status_ack = 1'b0;
        wait_cycles(2);
        pre_reset = 1'b0;

        test_power_up();
        test_sync_modes();
        test_channel_map();
        test_encoder();
        test_status();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- minimux.f
minimux_pkg.sv
power_control.sv
channel_map.sv
input_debouncer.sv
quad_decoder.sv
status_trigger.sv
minimux_top.sv
tb_minimux.sv
